/* hdl/cpu_pkg.sv */
package cpu_pkg;
        localparam int word_width = 16;
        localparam int reg_count = 4;
        localparam int reg_addr_width = $clog2(reg_count);
        localparam int link_reg = 2;            // jal and jrl write here.

        // instruction fields.
        localparam int op_msb = 15;
        localparam int op_lsb = 12;
        localparam int rs_msb = 11;
        localparam int rs_lsb = 10;
        localparam int rt_msb = 9;
        localparam int rt_lsb = 8;
        localparam int rd_msb = 7;
        localparam int rd_lsb = 6;
        localparam int func_msb = 5;
        localparam int func_lsb = 0;
        localparam int imm_msb = 7;
        localparam int imm_lsb = 0;
        localparam int target_msb = 11;
        localparam int target_lsb = 0;

        typedef enum logic [3:0] {
                op_bne = 4'd0, op_beq = 4'd1, op_bgz = 4'd2, op_blz = 4'd3,
                op_adi = 4'd4, op_ori = 4'd5, op_lhi = 4'd6,
                op_lwd = 4'd7, op_swd = 4'd8,
                op_jmp = 4'd9, op_jal = 4'd10,
                op_alu = 4'd15
        } opcode_e;

        typedef enum logic [5:0] {
                fn_add = 6'd0, fn_sub = 6'd1, fn_and = 6'd2, fn_orr = 6'd3,
                fn_not = 6'd4, fn_tcp = 6'd5, fn_shl = 6'd6, fn_shr = 6'd7,
                fn_jpr = 6'd25, fn_jrl = 6'd26, fn_wwd = 6'd28, fn_hlt = 6'd29
        } func_e;

        typedef enum logic [2:0] {
                fetch, fetch_wait, decode, execute, mem_access, mem_wait, write_back, halted
        } state_e;

        // first eight values line up with the R-type function codes.
        typedef enum logic [3:0] {
                alu_add, alu_sub, alu_and, alu_or, alu_not, alu_tcp, alu_shl, alu_shr,
                alu_lhi, alu_pass_b, alu_cmp_ne, alu_cmp_eq, alu_cmp_gz, alu_cmp_lz
        } alu_op_e;

        typedef enum logic [1:0] {dest_rt, dest_rd, dest_link} dest_sel_e;

        localparam logic [1:0] src_b_reg = 2'd0;
        localparam logic [1:0] src_b_one = 2'd1;
        localparam logic [1:0] src_b_sext = 2'd2;
        localparam logic [1:0] src_b_zext = 2'd3;

        localparam logic [1:0] pc_src_alu = 2'd0;       // pc + 1.
        localparam logic [1:0] pc_src_out = 2'd1;       // branch target held in alu_out.
        localparam logic [1:0] pc_src_target = 2'd2;
        localparam logic [1:0] pc_src_reg = 2'd3;
endpackage

/* hdl/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;
        import cpu_pkg::*;

        logic pc_write, pc_write_cond, i_or_d, mem_read, mem_write, ir_write, mdr_write;
        logic reg_write, mem_to_reg, pc_to_reg, alu_src_a;
        dest_sel_e reg_write_dest;
        logic [1:0] alu_src_b, pc_src;
        alu_op_e alu_op;

        modport master (output pc_write, pc_write_cond, i_or_d, mem_read, mem_write,
                ir_write, mdr_write, reg_write, reg_write_dest, mem_to_reg, pc_to_reg,
                alu_src_a, alu_src_b, alu_op, pc_src);
        modport slave (input pc_write, pc_write_cond, i_or_d, mem_read, mem_write,
                ir_write, mdr_write, reg_write, reg_write_dest, mem_to_reg, pc_to_reg,
                alu_src_a, alu_src_b, alu_op, pc_src);
endinterface

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
        input  logic [cpu_pkg::word_width-1:0] a,
        input  logic [cpu_pkg::word_width-1:0] b,
        input  cpu_pkg::alu_op_e op,
        output logic [cpu_pkg::word_width-1:0] result,
        output logic cond
);
        import cpu_pkg::*;

        localparam int half = word_width / 2;

        always_comb begin
                case (op)
                        alu_cmp_ne: cond = (a != b);
                        alu_cmp_eq: cond = (a == b);
                        alu_cmp_gz: cond = ($signed(a) > 0);
                        alu_cmp_lz: cond = a[word_width-1];
                        default: cond = 1'b0;
                endcase
        end

        always_comb begin
                case (op)
                        alu_add: result = a + b;
                        alu_sub: result = a - b;
                        alu_and: result = a & b;
                        alu_or: result = a | b;
                        alu_not: result = ~a;
                        alu_tcp: result = ~a + 1'b1;
                        alu_shl: result = {a[word_width-2:0], 1'b0};
                        alu_shr: result = {a[word_width-1], a[word_width-1:1]};   // arithmetic.
                        alu_lhi: result = {b[half-1:0], {half{1'b0}}};
                        alu_pass_b: result = b;
                        default: result = {{(word_width-1){1'b0}}, cond};
                endcase
        end
endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
        input  logic clk,
        input  logic rst,
        input  logic [cpu_pkg::reg_addr_width-1:0] read_addr1,
        input  logic [cpu_pkg::reg_addr_width-1:0] read_addr2,
        output logic [cpu_pkg::word_width-1:0] read_data1,
        output logic [cpu_pkg::word_width-1:0] read_data2,
        input  logic write_en,
        input  logic [cpu_pkg::reg_addr_width-1:0] write_addr,
        input  logic [cpu_pkg::word_width-1:0] write_data
);
        import cpu_pkg::*;

        logic [word_width-1:0] regs [reg_count];

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < reg_count; i++)
                                regs[i] <= '0;
                end else if (write_en) begin
                        regs[write_addr] <= write_data;
                end
        end

        assign read_data1 = regs[read_addr1];
        assign read_data2 = regs[read_addr2];
endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
        input  logic clk,
        input  logic rst,
        input  cpu_pkg::opcode_e opcode,
        input  cpu_pkg::func_e func_code,
        ctrl_if.master ctrl,
        output logic new_inst,
        output logic wwd,
        output logic halt
);
        import cpu_pkg::*;

        state_e state, state_next;
        alu_op_e exec_op;
        logic is_rtype, is_itype, is_load, is_store, is_jrel, is_jreg, is_jwrite;
        logic is_branch, is_lhi, is_wwd, is_halt;

        always_comb begin
                is_rtype = 1'b0;
                is_itype = 1'b0;
                is_load = 1'b0;
                is_store = 1'b0;
                is_jrel = 1'b0;
                is_jreg = 1'b0;
                is_jwrite = 1'b0;
                is_branch = 1'b0;
                is_lhi = 1'b0;
                is_wwd = 1'b0;
                is_halt = 1'b0;
                exec_op = alu_add;
                case (opcode)
                        op_adi, op_lwd, op_swd: begin
                                is_itype = 1'b1;
                                is_load = (opcode == op_lwd);
                                is_store = (opcode == op_swd);
                        end
                        op_ori: begin
                                is_itype = 1'b1;
                                exec_op = alu_or;
                        end
                        op_lhi: begin
                                is_itype = 1'b1;
                                is_lhi = 1'b1;
                                exec_op = alu_lhi;
                        end
                        op_bne, op_beq, op_bgz, op_blz: begin
                                is_branch = 1'b1;
                                exec_op = alu_op_e'(4'(alu_cmp_ne) + 4'(opcode));
                        end
                        op_jmp, op_jal: begin
                                is_jrel = 1'b1;
                                is_jwrite = (opcode == op_jal);
                        end
                        op_alu: begin
                                case (func_code)
                                        fn_add, fn_sub, fn_and, fn_orr,
                                        fn_not, fn_tcp, fn_shl, fn_shr: begin
                                                is_rtype = 1'b1;
                                                exec_op = alu_op_e'({1'b0, func_code[2:0]});
                                        end
                                        fn_jpr, fn_jrl: begin
                                                is_jreg = 1'b1;
                                                is_jwrite = (func_code == fn_jrl);
                                        end
                                        fn_wwd: is_wwd = 1'b1;
                                        fn_hlt: is_halt = 1'b1;
                                        default: ;
                                endcase
                        end
                        default: ;
                endcase
        end

        always_comb begin
                case (state)
                        fetch: state_next = fetch_wait;
                        fetch_wait: state_next = decode;
                        decode: state_next = is_halt ? halted : execute;
                        execute: begin
                                if (is_load || is_store)
                                        state_next = mem_access;
                                else if (is_rtype || is_itype)
                                        state_next = write_back;
                                else
                                        state_next = fetch;
                        end
                        mem_access: state_next = is_load ? mem_wait : fetch;
                        mem_wait: state_next = write_back;
                        write_back: state_next = fetch;
                        default: state_next = halted;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst)
                        state <= fetch;
                else
                        state <= state_next;
        end

        always_comb begin
                ctrl.pc_write = 1'b0;
                ctrl.pc_write_cond = 1'b0;
                ctrl.i_or_d = 1'b0;
                ctrl.mem_read = 1'b0;
                ctrl.mem_write = 1'b0;
                ctrl.ir_write = 1'b0;
                ctrl.mdr_write = 1'b0;
                ctrl.reg_write = 1'b0;
                ctrl.reg_write_dest = dest_rd;
                ctrl.mem_to_reg = 1'b0;
                ctrl.pc_to_reg = 1'b0;
                ctrl.alu_src_a = 1'b0;
                ctrl.alu_src_b = src_b_reg;
                ctrl.alu_op = alu_add;
                ctrl.pc_src = pc_src_alu;
                new_inst = (state == fetch);
                wwd = 1'b0;
                halt = 1'b0;
                case (state)
                        fetch: ctrl.mem_read = 1'b1;
                        fetch_wait: begin               // ir capture and pc + 1.
                                ctrl.ir_write = 1'b1;
                                ctrl.pc_write = 1'b1;
                                ctrl.alu_src_b = src_b_one;
                        end
                        decode: begin                   // branch target into alu_out.
                                ctrl.alu_src_b = src_b_sext;
                                halt = is_halt;
                        end
                        execute: begin
                                ctrl.alu_src_a = 1'b1;
                                ctrl.alu_op = exec_op;
                                if (is_itype)
                                        ctrl.alu_src_b = (is_lhi || exec_op == alu_or) ?
                                                src_b_zext : src_b_sext;
                                ctrl.pc_write_cond = is_branch;
                                ctrl.pc_write = is_jrel || is_jreg;
                                if (is_branch)
                                        ctrl.pc_src = pc_src_out;
                                else
                                        ctrl.pc_src = is_jreg ? pc_src_reg : pc_src_target;
                                ctrl.reg_write = is_jwrite;
                                ctrl.reg_write_dest = dest_link;
                                ctrl.pc_to_reg = 1'b1;
                                wwd = is_wwd;
                        end
                        mem_access: begin
                                ctrl.i_or_d = 1'b1;
                                ctrl.mem_read = is_load;
                                ctrl.mem_write = is_store;
                        end
                        mem_wait: ctrl.mdr_write = 1'b1;
                        write_back: begin
                                ctrl.reg_write = 1'b1;
                                ctrl.reg_write_dest = is_itype ? dest_rt : dest_rd;
                                ctrl.mem_to_reg = is_load;
                        end
                        default: ;
                endcase
        end

        assert property (@(posedge clk) disable iff (rst) !(ctrl.mem_read && ctrl.mem_write));
endmodule

/* hdl/datapath.sv */
`timescale 1ns/1ps

module datapath (
        input  logic clk,
        input  logic rst,
        ctrl_if.slave ctrl,
        output cpu_pkg::opcode_e opcode,
        output cpu_pkg::func_e func_code,
        output logic [cpu_pkg::word_width-1:0] wwd_value,
        output logic [cpu_pkg::word_width-1:0] mem_addr,
        output logic mem_read,
        output logic mem_write,
        output logic [cpu_pkg::word_width-1:0] mem_wdata,
        input  logic [cpu_pkg::word_width-1:0] mem_rdata
);
        import cpu_pkg::*;

        localparam int imm_pad = word_width - (imm_msb - imm_lsb + 1);

        logic [word_width-1:0] pc, ir, mdr, a_reg, b_reg, alu_out;
        logic [word_width-1:0] rd_data1, rd_data2, alu_a, alu_b, alu_result;
        logic [word_width-1:0] wb_data, next_pc, imm_sext, imm_zext;
        logic [reg_addr_width-1:0] wb_addr;
        logic alu_cond;

        assign opcode = opcode_e'(ir[op_msb:op_lsb]);
        assign func_code = func_e'(ir[func_msb:func_lsb]);
        assign imm_sext = {{imm_pad{ir[imm_msb]}}, ir[imm_msb:imm_lsb]};
        assign imm_zext = {{imm_pad{1'b0}}, ir[imm_msb:imm_lsb]};

        assign alu_a = ctrl.alu_src_a ? a_reg : pc;
        always_comb begin
                case (ctrl.alu_src_b)
                        src_b_reg: alu_b = b_reg;
                        src_b_one: alu_b = word_width'(1);
                        src_b_sext: alu_b = imm_sext;
                        default: alu_b = imm_zext;
                endcase
        end

        always_comb begin
                case (ctrl.pc_src)
                        pc_src_alu: next_pc = alu_result;
                        pc_src_out: next_pc = alu_out;
                        pc_src_target: next_pc = {pc[word_width-1:target_msb+1],
                                ir[target_msb:target_lsb]};
                        default: next_pc = a_reg;
                endcase
        end

        always_comb begin
                case (ctrl.reg_write_dest)
                        dest_rt: wb_addr = ir[rt_msb:rt_lsb];
                        dest_rd: wb_addr = ir[rd_msb:rd_lsb];
                        default: wb_addr = reg_addr_width'(link_reg);
                endcase
        end

        // pc already holds pc + 1 when jal or jrl reaches execute.
        assign wb_data = ctrl.pc_to_reg ? pc : (ctrl.mem_to_reg ? mdr : alu_out);

        always_ff @(posedge clk) begin
                if (rst)
                        pc <= '0;
                else if (ctrl.pc_write || (ctrl.pc_write_cond && alu_cond))
                        pc <= next_pc;
        end

        always_ff @(posedge clk) begin
                if (ctrl.ir_write)
                        ir <= mem_rdata;
                if (ctrl.mdr_write)
                        mdr <= mem_rdata;
                a_reg <= rd_data1;
                b_reg <= rd_data2;
                alu_out <= alu_result;
        end

        assign mem_addr = ctrl.i_or_d ? alu_out : pc;
        assign mem_read = ctrl.mem_read;
        assign mem_write = ctrl.mem_write;
        assign mem_wdata = b_reg;                       // rt holds the store data.
        assign wwd_value = a_reg;

        register_file u_regs (
                .clk(clk), .rst(rst),
                .read_addr1(ir[rs_msb:rs_lsb]), .read_addr2(ir[rt_msb:rt_lsb]),
                .read_data1(rd_data1), .read_data2(rd_data2),
                .write_en(ctrl.reg_write), .write_addr(wb_addr), .write_data(wb_data)
        );

        alu u_alu (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .result(alu_result), .cond(alu_cond));

        assert property (@(posedge clk) disable iff (rst) !(ctrl.ir_write && ctrl.mdr_write));
endmodule

/* hdl/output_port.sv */
`timescale 1ns/1ps

module output_port (
        input  logic clk,
        input  logic rst,
        input  logic new_inst,
        input  logic wwd,
        input  logic halt,
        input  logic [cpu_pkg::word_width-1:0] wwd_value,
        output logic [cpu_pkg::word_width-1:0] output_value,
        output logic output_valid,
        output logic halted,
        output logic [cpu_pkg::word_width-1:0] num_inst
);
        always_ff @(posedge clk) begin
                if (rst) begin
                        output_valid <= 1'b0;
                        halted <= 1'b0;
                        num_inst <= '0;
                end else begin
                        output_valid <= wwd;
                        if (halt)
                                halted <= 1'b1;                 // held until reset.
                        if (new_inst)
                                num_inst <= num_inst + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (wwd)
                        output_value <= wwd_value;
        end

        assert property (@(posedge clk) disable iff (rst) halted |-> !new_inst);
endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
        input  logic clk,
        input  logic rst,
        output logic [cpu_pkg::word_width-1:0] mem_addr,
        output logic mem_read,
        output logic mem_write,
        output logic [cpu_pkg::word_width-1:0] mem_wdata,
        input  logic [cpu_pkg::word_width-1:0] mem_rdata,
        output logic [cpu_pkg::word_width-1:0] output_value,
        output logic output_valid,
        output logic halted,
        output logic [cpu_pkg::word_width-1:0] num_inst
);
        import cpu_pkg::*;

        opcode_e opcode;
        func_e func_code;
        logic new_inst, wwd, halt;
        logic [word_width-1:0] wwd_value;

        ctrl_if ctrl ();

        control_unit u_ctrl (
                .clk(clk), .rst(rst), .opcode(opcode), .func_code(func_code),
                .ctrl(ctrl.master), .new_inst(new_inst), .wwd(wwd), .halt(halt)
        );

        datapath u_dp (
                .clk(clk), .rst(rst), .ctrl(ctrl.slave),
                .opcode(opcode), .func_code(func_code), .wwd_value(wwd_value),
                .mem_addr(mem_addr), .mem_read(mem_read), .mem_write(mem_write),
                .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
        );

        output_port u_out (
                .clk(clk), .rst(rst), .new_inst(new_inst), .wwd(wwd), .halt(halt),
                .wwd_value(wwd_value), .output_value(output_value),
                .output_valid(output_valid), .halted(halted), .num_inst(num_inst)
        );
endmodule

/* bench/tb_memory.sv */
`timescale 1ns/1ps

module tb_memory (
        input  logic clk,
        input  logic rst,
        input  logic [15:0] addr,
        input  logic read_en,
        input  logic write_en,
        input  logic [15:0] wdata,
        output logic [15:0] rdata,
        input  logic [15:0] exp_addr,
        input  logic [15:0] exp_data,
        output int write_count,
        output logic store_bad
);
        logic [15:0] mem [256];

        initial begin
                for (int i = 0; i < 256; i++)
                        mem[i] = 16'hc3a0 ^ {8'(i), 8'(i)};
                rdata = '0;
                write_count = 0;
                store_bad = 1'b0;
        end

        always @(posedge clk) begin
                logic [15:0] word;
                word = read_en ? mem[addr[7:0]] : 'x;   // data lives for one cycle only.
                if (write_en) begin
                        mem[addr[7:0]] <= wdata;
                        write_count <= write_count + 1;
                end
                #1 rdata = word;
        end

        store_addr: assert property (@(posedge clk) disable iff (rst)
                        write_en |-> addr == exp_addr)
                else begin
                        $display("MISMATCH time=%0t mem_addr expected=%h actual=%h",
                                $time, exp_addr, $sampled(addr));
                        store_bad = 1'b1;
                end

        store_data: assert property (@(posedge clk) disable iff (rst)
                        write_en |-> wdata == exp_data)
                else begin
                        $display("MISMATCH time=%0t mem_wdata expected=%h actual=%h",
                                $time, exp_data, $sampled(wdata));
                        store_bad = 1'b1;
                end
endmodule

/* bench/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
        import cpu_pkg::*;

        localparam int period = 8;
        localparam int reset_cycles = 10;
        localparam int max_inst = 200;
        localparam int worst_cycles = 7;        // lwd is the longest instruction.
        localparam int watchdog_ns = (reset_cycles + max_inst * worst_cycles) * period;

        logic clk, rst;
        logic [15:0] mem_addr, mem_wdata, mem_rdata, output_value, num_inst;
        logic mem_read, mem_write, output_valid, halted;
        logic [15:0] exp_addr, exp_data;
        logic store_bad;
        int write_count;

        logic [15:0] rv [4];                    // register values on the executed path.
        logic [15:0] exp_out [64];
        int exp_count, exp_inst, pc_b, out_idx, cyc;

        cpu_top DUT (
                .clk(clk), .rst(rst), .mem_addr(mem_addr), .mem_read(mem_read),
                .mem_write(mem_write), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
                .output_value(output_value), .output_valid(output_valid),
                .halted(halted), .num_inst(num_inst)
        );

        tb_memory u_mem (
                .clk(clk), .rst(rst), .addr(mem_addr), .read_en(mem_read),
                .write_en(mem_write), .wdata(mem_wdata), .rdata(mem_rdata),
                .exp_addr(exp_addr), .exp_data(exp_data),
                .write_count(write_count), .store_bad(store_bad)
        );

        function automatic logic [15:0] itype_word(opcode_e op, int rs, int rt, logic [7:0] imm);
                return {op, 2'(rs), 2'(rt), imm};
        endfunction

        function automatic logic [15:0] rtype_word(int rs, int rt, int rd, func_e fn);
                return {op_alu, 2'(rs), 2'(rt), 2'(rd), fn};
        endfunction

        function automatic logic [15:0] jump_word(opcode_e op, int target);
                return {op, 12'(target)};
        endfunction

        task automatic fail_run();
                $display("SIMULATION FAILED");
                $fatal(1);
        endtask

        task automatic put_word(logic [15:0] word, bit run);
                u_mem.mem[pc_b] = word;
                pc_b++;
                if (run)
                        exp_inst++;
        endtask

        task automatic push_expected(logic [15:0] value);
                exp_out[exp_count] = value;
                exp_count++;
        endtask

        task automatic imm_inst(opcode_e op, int rs, int rt, logic [7:0] imm, bit run);
                put_word(itype_word(op, rs, rt, imm), run);
                if (run) begin
                        case (op)
                                op_adi: rv[rt] = rv[rs] + {{8{imm[7]}}, imm};
                                op_ori: rv[rt] = rv[rs] | {8'h00, imm};
                                op_lhi: rv[rt] = {imm, 8'h00};
                                default: ;
                        endcase
                end
        endtask

        task automatic reg_inst(func_e fn, int rs, int rt, int rd);
                logic [15:0] a, b;
                a = rv[rs];
                b = rv[rt];
                put_word(rtype_word(rs, rt, rd, fn), 1'b1);
                case (fn)
                        fn_add: rv[rd] = a + b;
                        fn_sub: rv[rd] = a - b;
                        fn_and: rv[rd] = a & b;
                        fn_orr: rv[rd] = a | b;
                        fn_not: rv[rd] = ~a;
                        fn_tcp: rv[rd] = -a;
                        fn_shl: rv[rd] = a << 1;
                        fn_shr: rv[rd] = $signed(a) >>> 1;      // sign bit is kept.
                        default: ;
                endcase
        endtask

        task automatic show_reg(int rs);
                put_word(rtype_word(rs, 0, 0, fn_wwd), 1'b1);
                push_expected(rv[rs]);
        endtask

        // offset 1 skips a poison add on r1 when the branch is taken.
        task automatic branch_case(opcode_e op, int rs, int rt);
                bit taken;
                case (op)
                        op_bne: taken = rv[rs] != rv[rt];
                        op_beq: taken = rv[rs] == rv[rt];
                        op_bgz: taken = $signed(rv[rs]) > 16'sd0;
                        default: taken = rv[rs][15];
                endcase
                put_word(itype_word(op, rs, rt, 8'd1), 1'b1);
                imm_inst(op_adi, 1, 1, 8'h10, !taken);
                imm_inst(op_adi, 1, 1, 8'h01, 1'b1);
                show_reg(1);
        endtask

        task automatic build_program();
                logic [7:0] i0, i1, i2, i3;
                int base;
                i0 = 8'($urandom) | 8'h80;              // negative, so sign extension shows.
                i1 = 8'($urandom) | 8'h80;              // top bit set, so zero extension shows.
                i2 = 8'($urandom);
                i3 = 8'($urandom);
                pc_b = 0;
                exp_count = 0;
                exp_inst = 0;
                for (int r = 0; r < 4; r++)
                        rv[r] = '0;
                imm_inst(op_adi, 0, 1, i0, 1'b1);
                show_reg(1);
                imm_inst(op_ori, 0, 3, i1, 1'b1);
                show_reg(3);
                for (int k = 0; k < 8; k++) begin
                        reg_inst(func_e'(6'(k)), 1, 3, 0);
                        show_reg(0);
                end
                imm_inst(op_lhi, 0, 3, i2, 1'b1);
                show_reg(3);
                imm_inst(op_lhi, 0, 0, 8'h00, 1'b1);
                imm_inst(op_ori, 0, 0, 8'he0, 1'b1);    // data area well past the code.
                put_word(itype_word(op_swd, 0, 1, 8'h04), 1'b1);
                exp_addr = rv[0] + 16'h0004;
                exp_data = rv[1];
                put_word(itype_word(op_lwd, 0, 3, 8'h04), 1'b1);
                rv[3] = rv[1];
                show_reg(3);
                imm_inst(op_lhi, 0, 3, {1'b1, i3[6:0]}, 1'b1);
                imm_inst(op_lhi, 0, 1, 8'h00, 1'b1);
                // r0 positive and r3 negative give one taken and one fall-through per kind.
                branch_case(op_bne, 0, 3);
                branch_case(op_bne, 0, 0);
                branch_case(op_beq, 0, 0);
                branch_case(op_beq, 0, 3);
                branch_case(op_bgz, 0, 0);
                branch_case(op_bgz, 3, 0);
                branch_case(op_blz, 3, 0);
                branch_case(op_blz, 0, 0);
                put_word(jump_word(op_jmp, pc_b + 2), 1'b1);
                imm_inst(op_adi, 1, 1, 8'h10, 1'b0);
                imm_inst(op_adi, 1, 1, 8'h01, 1'b1);
                show_reg(1);
                base = pc_b;
                put_word(jump_word(op_jal, base + 3), 1'b1);
                put_word(rtype_word(2, 0, 0, fn_wwd), 1'b1);    // runs after the return.
                put_word(jump_word(op_jmp, base + 6), 1'b1);
                imm_inst(op_adi, 1, 1, 8'h01, 1'b1);
                show_reg(1);
                put_word(rtype_word(2, 0, 0, fn_jpr), 1'b1);
                rv[2] = 16'(base + 1);
                push_expected(rv[2]);
                base = pc_b;
                imm_inst(op_lhi, 0, 0, 8'h00, 1'b1);
                imm_inst(op_ori, 0, 0, 8'(base + 5), 1'b1);
                put_word(rtype_word(0, 0, 0, fn_jrl), 1'b1);
                rv[2] = 16'(base + 3);
                imm_inst(op_adi, 1, 1, 8'h10, 1'b0);
                imm_inst(op_adi, 1, 1, 8'h10, 1'b0);
                show_reg(2);
                put_word(rtype_word(0, 0, 0, fn_hlt), 1'b1);
        endtask

        initial begin
                clk = 1'b0;
                forever #(period / 2) clk = ~clk;
        end

        initial begin
                rst = 1'b1;
                cyc = 0;
                out_idx = 0;
                void'($urandom(15));
                #1;
                build_program();                        // written over the fill pattern.
                repeat (reset_cycles) @(posedge clk);
                #1 rst = 1'b0;
                wait (halted);
                repeat (8) @(posedge clk);
                $display("SIMULATION PASSED");
                $finish;
        end

        initial begin
                #(watchdog_ns);
                $display("timeout: the core did not halt within %0d ns", watchdog_ns);
                fail_run();
        end

        always @(posedge clk) begin
                cyc <= cyc + 1;
                if (output_valid)
                        out_idx <= out_idx + 1;
        end

        always @(posedge store_bad)
                fail_run();

        reset_state: assert property (@(posedge clk) ((rst && cyc > 0) || $fell(rst)) |->
                        (!mem_write && !output_valid && !halted && num_inst == '0))
                else begin
                        $display("time %0t: outputs left their reset values around reset", $time);
                        fail_run();
                end

        first_fetch: assert property (@(posedge clk) $fell(rst) |-> mem_read && mem_addr == '0)
                else begin
                        $display("time %0t: first access after reset is not a read of word 0",
                                $time);
                        fail_run();
                end

        out_check: assert property (@(posedge clk) disable iff (rst) output_valid |->
                        (out_idx < exp_count && output_value == exp_out[out_idx]))
                else begin
                        if ($sampled(out_idx) >= exp_count)
                                $display("time %0t: WWD output beyond the expected list", $time);
                        else
                                $display("MISMATCH time=%0t output_value expected=%h actual=%h",
                                        $time, exp_out[$sampled(out_idx)], $sampled(output_value));
                        fail_run();
                end

        inst_count: assert property (@(posedge clk) $rose(halted) |->
                        num_inst == 16'(exp_inst))
                else begin
                        $display("MISMATCH time=%0t num_inst expected=%0d actual=%0d",
                                $time, exp_inst, $sampled(num_inst));
                        fail_run();
                end

        halt_totals: assert property (@(posedge clk) $rose(halted) |->
                        (out_idx == exp_count && write_count == 1))
                else begin
                        $display("time %0t: halted before all outputs and the store were seen",
                                $time);
                        fail_run();
                end

        halt_quiet: assert property (@(posedge clk) disable iff (rst) halted |->
                        (!mem_read && !output_valid))
                else begin
                        $display("time %0t: memory read or output after halt", $time);
                        fail_run();
                end

        halt_held: assert property (@(posedge clk) disable iff (rst) !$fell(halted))
                else begin
                        $display("time %0t: halted dropped without a reset", $time);
                        fail_run();
                end
endmodule

/* filelist.f */
hdl/cpu_pkg.sv
hdl/ctrl_if.sv
hdl/alu.sv
hdl/register_file.sv
hdl/control_unit.sv
hdl/datapath.sv
hdl/output_port.sv
hdl/cpu_top.sv
bench/tb_memory.sv
bench/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
